// ==== common/tiny_rv_consts.svh ====
`ifndef TINY_RV_CONSTS_SVH
`define TINY_RV_CONSTS_SVH

// --------------------
// opcodes
// --------------------
`define INST_TYPE_I     7'b0010011
`define INST_TYPE_R_M   7'b0110011

// --------------------
// funct fields
// --------------------
`define INST_ADDI       3'b000
`define INST_ADD_SUB    3'b000
`define FUNCT7_SUB      7'b0100000

// --------------------
// widths and sizes
// --------------------
`define XLEN            32
`define REG_NUM         32
`define PC_STEP         32'd4

`endif

// ==== common/tiny_rv_pkg.sv ====
package tiny_rv_pkg;

    // --------------------
    // data path vectors
    // --------------------

    // instructions, operands, results and the pc.
    typedef logic [31:0] word_t;

    // register index, x0 to x31.
    typedef logic [4:0] reg_addr_t;

    // --------------------
    // instruction fields
    // --------------------

    typedef logic [6:0] opcode_t;

    typedef logic [2:0] funct3_t;

    typedef logic [6:0] funct7_t;

endpackage

// ==== design/ex.sv ====
`include "tiny_rv_consts.svh"

module ex (
    // from id_ex.
    input  logic                   valid_i,
    input  tiny_rv_pkg::word_t     inst_i,
    input  tiny_rv_pkg::word_t     inst_addr_i,
    input  tiny_rv_pkg::word_t     op1_i,
    input  tiny_rv_pkg::word_t     op2_i,
    input  tiny_rv_pkg::reg_addr_t rd_addr_i,
    input  logic                   reg_wen_i,

    // retire and register write.
    output logic                   wb_valid_o,
    output tiny_rv_pkg::word_t     wb_pc_o,
    output tiny_rv_pkg::word_t     rd_wdata_o,
    output tiny_rv_pkg::reg_addr_t rd_waddr_o,
    output logic                   reg_wen_o
);

    tiny_rv_pkg::opcode_t opcode;
    tiny_rv_pkg::funct3_t funct3;
    tiny_rv_pkg::funct7_t funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        rd_wdata_o = '0;
        rd_waddr_o = '0;
        reg_wen_o  = 1'b0;
        case (opcode)
            `INST_TYPE_I: begin
                if (funct3 == `INST_ADDI) begin
                    rd_wdata_o = op1_i + op2_i;
                    rd_waddr_o = rd_addr_i;
                    reg_wen_o  = valid_i & reg_wen_i;
                end
            end
            `INST_TYPE_R_M: begin
                if (funct3 == `INST_ADD_SUB) begin
                    if (funct7 == `FUNCT7_SUB) begin
                        // rs1 minus rs2.
                        rd_wdata_o = op1_i - op2_i;
                        rd_waddr_o = rd_addr_i;
                        reg_wen_o  = valid_i & reg_wen_i;
                    end else if (funct7 == tiny_rv_pkg::funct7_t'(0)) begin
                        rd_wdata_o = op1_i + op2_i;
                        rd_waddr_o = rd_addr_i;
                        reg_wen_o  = valid_i & reg_wen_i;
                    end
                end
            end
            default: begin
                // anything else retires as a no-op.
                reg_wen_o = 1'b0;
            end
        endcase
    end

    assign wb_valid_o = valid_i;
    assign wb_pc_o    = inst_addr_i;

endmodule

// ==== design/id.sv ====
`include "tiny_rv_consts.svh"

module id (
    input  tiny_rv_pkg::word_t     inst_i,
    input  tiny_rv_pkg::word_t     inst_addr_i,
    input  logic                   valid_i,

    // register file read port.
    output tiny_rv_pkg::reg_addr_t rs1_addr_o,
    output tiny_rv_pkg::reg_addr_t rs2_addr_o,
    input  tiny_rv_pkg::word_t     rs1_data_i,
    input  tiny_rv_pkg::word_t     rs2_data_i,

    // towards id_ex.
    output tiny_rv_pkg::word_t     op1_o,
    output tiny_rv_pkg::word_t     op2_o,
    output tiny_rv_pkg::reg_addr_t rd_addr_o,
    output logic                   reg_wen_o,
    output tiny_rv_pkg::word_t     inst_o,
    output tiny_rv_pkg::word_t     inst_addr_o
);

    tiny_rv_pkg::opcode_t   opcode;
    tiny_rv_pkg::funct3_t   funct3;
    tiny_rv_pkg::funct7_t   funct7;
    tiny_rv_pkg::reg_addr_t rd;
    tiny_rv_pkg::word_t     imm_ext;
    logic                   supported;

    // --------------------
    // field split
    // --------------------
    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // i-type immediate, sign extended.
    assign imm_ext = {{(`XLEN - 12){inst_i[31]}}, inst_i[31:20]};

    // --------------------
    // operands
    // --------------------
    always_comb begin
        supported = 1'b0;
        op1_o     = rs1_data_i;
        op2_o     = '0;
        case (opcode)
            `INST_TYPE_I: begin
                op2_o     = imm_ext;
                supported = (funct3 == `INST_ADDI);
            end
            `INST_TYPE_R_M: begin
                op2_o     = rs2_data_i;
                supported = (funct3 == `INST_ADD_SUB) &&
                            ((funct7 == tiny_rv_pkg::funct7_t'(0)) ||
                             (funct7 == `FUNCT7_SUB));
            end
            default: begin
                op1_o = '0;
            end
        endcase
    end

    // writes to x0 are dropped here already.
    assign reg_wen_o = valid_i & supported & (rd != '0);
    assign rd_addr_o = rd;

    assign inst_o      = inst_i;
    assign inst_addr_o = inst_addr_i;

endmodule

// ==== design/id_ex.sv ====
module id_ex (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   advance_i,

    input  logic                   valid_i,
    input  tiny_rv_pkg::word_t     inst_i,
    input  tiny_rv_pkg::word_t     inst_addr_i,
    input  tiny_rv_pkg::word_t     op1_i,
    input  tiny_rv_pkg::word_t     op2_i,
    input  tiny_rv_pkg::reg_addr_t rd_addr_i,
    input  logic                   reg_wen_i,

    output logic                   valid_o,
    output tiny_rv_pkg::word_t     inst_o,
    output tiny_rv_pkg::word_t     inst_addr_o,
    output tiny_rv_pkg::word_t     op1_o,
    output tiny_rv_pkg::word_t     op2_o,
    output tiny_rv_pkg::reg_addr_t rd_addr_o,
    output logic                   reg_wen_o
);

    // --------------------
    // control bits
    // --------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o   <= 1'b0;
            reg_wen_o <= 1'b0;
        end else if (advance_i) begin
            valid_o   <= valid_i;
            reg_wen_o <= reg_wen_i;
        end
    end

    // --------------------
    // payload
    // --------------------

    // held as is while execute is stalled.
    always_ff @(posedge clk) begin
        if (advance_i) begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
            op1_o       <= op1_i;
            op2_o       <= op2_i;
            rd_addr_o   <= rd_addr_i;
        end
    end

endmodule

// ==== design/if_id.sv ====
`include "tiny_rv_consts.svh"

module if_id (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               advance_i,
    input  logic               inst_valid_i,
    input  tiny_rv_pkg::word_t inst_i,
    output logic               inst_ready_o,
    output logic               valid_o,
    output tiny_rv_pkg::word_t inst_o,
    output tiny_rv_pkg::word_t inst_addr_o
);

    logic               valid_q;
    logic               accept;
    tiny_rv_pkg::word_t inst_q;
    tiny_rv_pkg::word_t inst_addr_q;
    tiny_rv_pkg::word_t pc_cnt_q;

    // free when empty or when the held instruction moves on.
    assign inst_ready_o = ~valid_q | advance_i;
    assign accept       = inst_valid_i & inst_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q  <= 1'b0;
            pc_cnt_q <= '0;
        end else if (accept) begin
            valid_q  <= 1'b1;
            pc_cnt_q <= pc_cnt_q + `PC_STEP;
        end else if (advance_i) begin
            valid_q <= 1'b0;
        end
    end

    // each accepted word is stamped with the running pc.
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q      <= inst_i;
            inst_addr_q <= pc_cnt_q;
        end
    end

    assign valid_o     = valid_q;
    assign inst_o      = inst_q;
    assign inst_addr_o = inst_addr_q;

endmodule

// ==== design/regs.sv ====
`include "tiny_rv_consts.svh"

module regs (
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic                   wen_i,
    input  tiny_rv_pkg::reg_addr_t waddr_i,
    input  tiny_rv_pkg::word_t     wdata_i,

    input  tiny_rv_pkg::reg_addr_t raddr1_i,
    input  tiny_rv_pkg::reg_addr_t raddr2_i,
    output tiny_rv_pkg::word_t     rdata1_o,
    output tiny_rv_pkg::word_t     rdata2_o
);

    tiny_rv_pkg::word_t regs_q [`REG_NUM];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // --------------------
    // read with bypass
    // --------------------
    always_comb begin
        if (raddr1_i == '0) rdata1_o = '0;
        else if (wen_i && (raddr1_i == waddr_i)) rdata1_o = wdata_i;
        else rdata1_o = regs_q[raddr1_i];
    end

    always_comb begin
        if (raddr2_i == '0) rdata2_o = '0;
        else if (wen_i && (raddr2_i == waddr_i)) rdata2_o = wdata_i;
        else rdata2_o = regs_q[raddr2_i];
    end

endmodule

// ==== design/tiny_rv_core.sv ====
module tiny_rv_core (
    input  logic                   clk,
    input  logic                   reset_i,

    // instruction input.
    input  logic                   inst_valid_i,
    input  tiny_rv_pkg::word_t     inst_i,
    output logic                   inst_ready_o,

    // retire port.
    output logic                   wb_valid_o,
    input  logic                   wb_ready_i,
    output tiny_rv_pkg::word_t     wb_pc_o,
    output logic                   wb_wen_o,
    output tiny_rv_pkg::reg_addr_t wb_rd_o,
    output tiny_rv_pkg::word_t     wb_data_o
);

    logic                   advance;
    logic                   regs_wen;

    // fetch/decode register outputs.
    logic                   if_valid;
    tiny_rv_pkg::word_t     if_inst;
    tiny_rv_pkg::word_t     if_inst_addr;

    // decode outputs.
    tiny_rv_pkg::reg_addr_t rs1_addr;
    tiny_rv_pkg::reg_addr_t rs2_addr;
    tiny_rv_pkg::word_t     rs1_data;
    tiny_rv_pkg::word_t     rs2_data;
    tiny_rv_pkg::word_t     id_op1;
    tiny_rv_pkg::word_t     id_op2;
    tiny_rv_pkg::reg_addr_t id_rd_addr;
    logic                   id_reg_wen;
    tiny_rv_pkg::word_t     id_inst;
    tiny_rv_pkg::word_t     id_inst_addr;

    // decode/execute register outputs.
    logic                   ex_valid;
    tiny_rv_pkg::word_t     ex_inst;
    tiny_rv_pkg::word_t     ex_inst_addr;
    tiny_rv_pkg::word_t     ex_op1;
    tiny_rv_pkg::word_t     ex_op2;
    tiny_rv_pkg::reg_addr_t ex_rd_addr;
    logic                   ex_reg_wen;

    // --------------------
    // stall control
    // --------------------

    // the pipe moves when execute is empty or its instruction retires.
    assign advance  = ~ex_valid | wb_ready_i;
    assign regs_wen = wb_valid_o & wb_ready_i & wb_wen_o;

    if_id if_id_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .advance_i    (advance),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .valid_o      (if_valid),
        .inst_o       (if_inst),
        .inst_addr_o  (if_inst_addr)
    );

    id id_i (
        .inst_i      (if_inst),
        .inst_addr_i (if_inst_addr),
        .valid_i     (if_valid),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .op1_o       (id_op1),
        .op2_o       (id_op2),
        .rd_addr_o   (id_rd_addr),
        .reg_wen_o   (id_reg_wen),
        .inst_o      (id_inst),
        .inst_addr_o (id_inst_addr)
    );

    id_ex id_ex_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .advance_i   (advance),
        .valid_i     (if_valid),
        .inst_i      (id_inst),
        .inst_addr_i (id_inst_addr),
        .op1_i       (id_op1),
        .op2_i       (id_op2),
        .rd_addr_i   (id_rd_addr),
        .reg_wen_i   (id_reg_wen),
        .valid_o     (ex_valid),
        .inst_o      (ex_inst),
        .inst_addr_o (ex_inst_addr),
        .op1_o       (ex_op1),
        .op2_o       (ex_op2),
        .rd_addr_o   (ex_rd_addr),
        .reg_wen_o   (ex_reg_wen)
    );

    ex ex_i (
        .valid_i     (ex_valid),
        .inst_i      (ex_inst),
        .inst_addr_i (ex_inst_addr),
        .op1_i       (ex_op1),
        .op2_i       (ex_op2),
        .rd_addr_i   (ex_rd_addr),
        .reg_wen_i   (ex_reg_wen),
        .wb_valid_o  (wb_valid_o),
        .wb_pc_o     (wb_pc_o),
        .rd_wdata_o  (wb_data_o),
        .rd_waddr_o  (wb_rd_o),
        .reg_wen_o   (wb_wen_o)
    );

    regs regs_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .wen_i    (regs_wen),
        .waddr_i  (wb_rd_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the core with its testbench and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tiny_rv_core_tb \
    -f tiny_rv_core.f \
    --Mdir obj_dir \
    -o tiny_rv_core_sim

./obj_dir/tiny_rv_core_sim

// ==== testbench/tiny_rv_core_input.txt ====
# columns: instruction word (hex), expected wb_wen_o, expected wb_rd_o (hex), expected wb_data_o
# lines starting with # are skipped; text after the fourth column is a note.
# back-to-back burst, no back-pressure
00538093 1 01 00000005 addi x1, x7, 5
ffd08113 1 02 00000002 addi x2, x1, -3
002081b3 1 03 00000007 add  x3, x1, x2
40118233 1 04 00000002 sub  x4, x3, x1
403082b3 1 05 fffffffe sub  x5, x1, x3
7ff00313 1 06 000007ff addi x6, x0, 2047
80000393 1 07 fffff800 addi x7, x0, -2048
00730433 1 08 ffffffff add  x8, x6, x7
00140493 1 09 00000000 addi x9, x8, 1
06408013 0 00 00000069 addi x0, x1, 100
00100533 1 0a 00000005 add  x10, x0, x1
40a50533 1 0a 00000000 sub  x10, x10, x10
# unsupported encodings and x0 writes
00000000 0 00 00000000 all zero word
00109093 0 00 00000000 slli x1, x1, 1
02108133 0 00 00000000 mul  x2, x1, x1
0020f1b3 0 00 00000000 and  x3, x1, x2
002080b3 1 01 00000007 add  x1, x1, x2
40208033 0 00 00000005 sub  x0, x1, x2
000005b3 1 0b 00000000 add  x11, x0, x0
# random gaps and back-pressure
fff28613 1 0c fffffffd addi x12, x5, -1
40c006b3 1 0d 00000003 sub  x13, x0, x12
00d68733 1 0e 00000006 add  x14, x13, x13
12370713 1 0e 00000129 addi x14, x14, 0x123
406387b3 1 0f fffff001 sub  x15, x7, x6
00e78833 1 10 fffff12a add  x16, x15, x14
7ff80f93 1 1f fffff929 addi x31, x16, 2047
41f488b3 1 11 000006d7 sub  x17, x9, x31
01100933 1 12 000006d7 add  x18, x0, x17
00000013 0 00 00000000 addi x0, x0, 0
05500993 1 13 00000055 addi x19, x0, 0x55

// ==== testbench/tiny_rv_core_tb.sv ====
`include "tiny_rv_consts.svh"

module tiny_rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                 CLK_PERIOD      = 8;
    localparam int                 BURST_LEN       = 12;
    localparam int                 IDLE_CYCLES     = 4;
    localparam int                 CYCLES_PER_LINE = 40;
    localparam tiny_rv_pkg::word_t LFSR_SEED       = 32'hb138_c0ff;

    logic                   clk;
    logic                   reset_i;
    logic                   inst_valid_i;
    tiny_rv_pkg::word_t     inst_i;
    logic                   inst_ready_o;
    logic                   wb_valid_o;
    logic                   wb_ready_i;
    tiny_rv_pkg::word_t     wb_pc_o;
    logic                   wb_wen_o;
    tiny_rv_pkg::reg_addr_t wb_rd_o;
    tiny_rv_pkg::word_t     wb_data_o;

    // one entry per line of the input file.
    tiny_rv_pkg::word_t     inst_list [$];
    logic                   wen_list [$];
    tiny_rv_pkg::reg_addr_t rd_list [$];
    tiny_rv_pkg::word_t     data_list [$];

    int                     n_lines;
    int                     ret_count;
    logic                   loaded;
    logic                   reset_released;
    tiny_rv_pkg::word_t     gap_state;
    tiny_rv_pkg::word_t     ready_state;

    tiny_rv_core tiny_rv_core_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_pc_o      (wb_pc_o),
        .wb_wen_o     (wb_wen_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input tiny_rv_pkg::word_t got, input tiny_rv_pkg::word_t expected,
                              input string what);
        if (got !== expected) begin
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Checks failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg(input tiny_rv_pkg::reg_addr_t got,
                             input tiny_rv_pkg::reg_addr_t expected, input string what);
        if (got !== expected) begin
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Checks failed");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, expected);
            $display("Checks failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // --------------------
    // random bits
    // --------------------
    function automatic tiny_rv_pkg::word_t lfsr_step(input tiny_rv_pkg::word_t state);
        tiny_rv_pkg::word_t next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic take_bit(inout tiny_rv_pkg::word_t state, output logic b);
        b     = state[0];
        state = lfsr_step(state);
    endtask

    task automatic pick_gap(output int gap);
        logic b0;
        logic b1;
        take_bit(gap_state, b0);
        take_bit(gap_state, b1);
        gap = 0;
        if (b0) gap += 1;
        if (b1) gap += 2;
    endtask

    task automatic load_inputs();
        int                     fd;
        int                     fields;
        string                  line;
        tiny_rv_pkg::word_t     word;
        logic                   wen;
        tiny_rv_pkg::reg_addr_t rd;
        tiny_rv_pkg::word_t     data;
        fd = $fopen("testbench/tiny_rv_core_input.txt", "r");
        if (fd == 0) begin
            $display("Checks failed");
            $fatal(1, "cannot open the input file testbench/tiny_rv_core_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.substr(0, 0) == "#" || line.substr(0, 0) == "\n") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h", word, wen, rd, data);
            if (fields != 4) begin
                $display("Checks failed");
                $fatal(1, "the input file has a line that does not hold four fields");
            end
            inst_list.push_back(word);
            wen_list.push_back(wen);
            rd_list.push_back(rd);
            data_list.push_back(data);
        end
        $fclose(fd);
        n_lines = inst_list.size();
    endtask

    // holds the word on the port until the core takes it.
    task automatic send_inst(input tiny_rv_pkg::word_t word);
        logic accepted;
        accepted     = 1'b0;
        inst_valid_i = 1'b1;
        inst_i       = word;
        while (!accepted) begin
            #1;
            accepted = inst_ready_o;
            @(negedge clk);
        end
        inst_valid_i = 1'b0;
    endtask

    task automatic check_retire();
        if (ret_count >= n_lines) begin
            $display("Checks failed");
            $fatal(1, "an instruction retired after the last one of the input file");
        end else begin
            check_word(wb_pc_o, tiny_rv_pkg::word_t'(ret_count) * `PC_STEP, "wb_pc_o");
            check_flag(wb_wen_o, wen_list[ret_count], "wb_wen_o");
            check_reg(wb_rd_o, rd_list[ret_count], "wb_rd_o");
            check_word(wb_data_o, data_list[ret_count], "wb_data_o");
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        int gap;
        reset_i        = 1'b1;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        loaded         = 1'b0;
        reset_released = 1'b0;
        gap_state      = LFSR_SEED;
        load_inputs();
        if (n_lines == 0) begin
            $display("Checks failed");
            $fatal(1, "the input file holds no instructions");
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i        = 1'b0;
        reset_released = 1'b1;
        // an empty pipe must not retire anything.
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            #1;
            check_flag(wb_valid_o, 1'b0, "wb_valid_o before any instruction");
            check_flag(inst_ready_o, 1'b1, "inst_ready_o after reset");
        end
        @(negedge clk);
        for (int i = 0; i < n_lines; i++) begin
            if (i >= BURST_LEN) begin
                pick_gap(gap);
                repeat (gap) @(negedge clk);
            end
            send_inst(inst_list[i]);
        end
        wait (ret_count == n_lines);
        repeat (IDLE_CYCLES) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    // --------------------
    // back-pressure and monitor
    // --------------------
    initial begin : retire_side
        logic b0;
        logic b1;
        wb_ready_i  = 1'b1;
        ret_count   = 0;
        ready_state = LFSR_SEED;
        wait (reset_released);
        forever begin
            @(negedge clk);
            // the first burst runs without back-pressure.
            if (ret_count >= BURST_LEN) begin
                take_bit(ready_state, b0);
                take_bit(ready_state, b1);
                wb_ready_i = b0 | b1;
            end else begin
                wb_ready_i = 1'b1;
            end
            #1;
            if (wb_valid_o && wb_ready_i) begin
                check_retire();
                ret_count++;
            end
        end
    end

    initial begin
        wait (loaded);
        #(n_lines * CYCLES_PER_LINE * CLK_PERIOD);
        $display("Checks failed");
        $fatal(1, "timeout: not every instruction retired in time");
    end

endmodule

// ==== tiny_rv_core.f ====
+incdir+common
common/tiny_rv_pkg.sv
design/if_id.sv
design/id.sv
design/id_ex.sv
design/ex.sv
design/regs.sv
design/tiny_rv_core.sv
testbench/tiny_rv_core_tb.sv
